// File: list.f
src/fm_map_pkg.sv
src/fm_slot_pkg.sv
src/fm_wr_if.sv
src/fm_shreg.sv
src/fm_keyon.sv
src/fm_apb_host.sv
src/fm_slot_regs.sv
src/fm_alg_route.sv
src/fm_regs_top.sv
verification/fm_regs_checker.sv
verification/fm_regs_tb.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module fm_regs_tb -f list.f -o fm_regs_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/fm_regs_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Something failed" "$log"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation passed"
exit 0

// File: src/fm_alg_route.sv
`timescale 1ns/1ps

module fm_alg_route (
	input  fm_slot_pkg::fm_stage_e stage,
	input  logic [2:0]             alg,
	output logic                   carrier
);

	always_comb begin
		case (alg)
			// serial and mixed chains end on S4 only
			3'd0, 3'd1, 3'd2, 3'd3: begin
				carrier = (stage == fm_slot_pkg::S4);
			end
			// two pairs
			3'd4: begin
				carrier = (stage == fm_slot_pkg::S2) || (stage == fm_slot_pkg::S4);
			end
			// S1 modulates the others
			3'd5, 3'd6: begin
				carrier = (stage != fm_slot_pkg::S1);
			end
			default: begin
				carrier = 1'b1;
			end
		endcase
	end

endmodule

// File: src/fm_apb_host.sv
`timescale 1ns/1ps

module fm_apb_host (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [fm_map_pkg::ADDR_W-1:0]   paddr,
	input  logic [7:0]                      pwdata,
	output logic                            pready,
	output logic                            pslverr,
	fm_wr_if.host                           wr
);

	typedef enum logic [1:0] {IDLE, WAIT_DONE, RESP} host_st_e;

	host_st_e state;

	logic [3:0] kind_raw;
	logic [fm_slot_pkg::CH_W-1:0] ch_raw;
	logic [fm_slot_pkg::OP_W-1:0] op_raw;
	logic access;
	logic bad;

	assign kind_raw = paddr[fm_map_pkg::KIND_MSB:fm_map_pkg::KIND_LSB];
	assign ch_raw   = paddr[fm_map_pkg::CH_MSB:fm_map_pkg::CH_LSB];
	assign op_raw   = paddr[fm_map_pkg::OP_MSB:fm_map_pkg::OP_LSB];

	// new access phase seen only while idle
	assign access = psel && penable && (state == IDLE);
	assign bad = !pwrite || (kind_raw >= fm_map_pkg::NUM_KINDS) ||
		(ch_raw >= fm_slot_pkg::NUM_CH);

	// errors finish in the first access cycle
	assign pready  = (state == RESP) || (access && bad);
	assign pslverr = access && bad;

	assign wr.req = (state == WAIT_DONE);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:      if (access && !bad) state <= WAIT_DONE;
				WAIT_DONE: if (wr.done) state <= RESP;
				default:   state <= IDLE;
			endcase
		end
	end

	// request fields, held until done
	always_ff @(posedge clk) begin
		if (access && !bad) begin
			wr.kind <= fm_map_pkg::fm_reg_e'(kind_raw);
			wr.ch   <= ch_raw;
			wr.op   <= op_raw;
			wr.data <= pwdata;
		end
	end

endmodule

// File: src/fm_keyon.sv
`timescale 1ns/1ps

module fm_keyon (
	input  logic                               clk,
	input  logic                               rst,
	input  logic [fm_slot_pkg::SLOT_W-1:0]     slot,
	input  logic                               kon_req,
	input  logic [fm_slot_pkg::CH_W-1:0]       kon_ch,
	input  logic [fm_slot_pkg::NUM_OPS-1:0]    kon_mask,
	output logic                               keyon,
	output logic                               keyoff
);

	logic [fm_slot_pkg::NUM_OPS-1:0] pend_v [fm_slot_pkg::NUM_CH];
	logic [fm_slot_pkg::NUM_OPS-1:0] pend_m [fm_slot_pkg::NUM_CH];

	logic [fm_slot_pkg::CH_W-1:0] s_ch;
	logic [fm_slot_pkg::OP_W-1:0] s_grp;
	logic [fm_slot_pkg::NUM_OPS-1:0] grp_bit;
	logic load_now;
	logic req_in, req_out;
	logic app_out;

	assign s_ch    = fm_slot_pkg::slot_ch(slot);
	assign s_grp   = fm_slot_pkg::slot_grp(slot);
	assign grp_bit = fm_slot_pkg::NUM_OPS'(1) << s_grp;

	// the write lands on group 0 of its channel, the rest wait for their slots
	assign load_now = kon_req && (s_ch == kon_ch);

	always_comb begin
		if (load_now)
			req_in = kon_mask[s_grp];
		else if (pend_v[s_ch][s_grp])
			req_in = pend_m[s_ch][s_grp];
		else
			req_in = req_out;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < fm_slot_pkg::NUM_CH; i++)
				pend_v[i] <= '0;
		end else begin
			pend_v[s_ch] <= pend_v[s_ch] & ~grp_bit;
			if (kon_req)
				pend_v[kon_ch] <= load_now ? ~grp_bit : '1;
		end
	end

	always_ff @(posedge clk) begin
		if (kon_req)
			pend_m[kon_ch] <= kon_mask;
	end

	fm_shreg #(.WIDTH(1), .STAGES(fm_slot_pkg::NUM_SLOTS)) i_req_mem (
		.clk  (clk),
		.rst  (rst),
		.din  (req_in),
		.dout (req_out)
	);

	// applied state catches up with the request as the slot passes
	fm_shreg #(.WIDTH(1), .STAGES(fm_slot_pkg::NUM_SLOTS)) i_app_mem (
		.clk  (clk),
		.rst  (rst),
		.din  (req_out),
		.dout (app_out)
	);

	assign keyon  = req_out && !app_out;
	assign keyoff = !req_out && app_out;

endmodule

// File: src/fm_map_pkg.sv
package fm_map_pkg;

	// register kinds, selected by paddr[11:8]
	typedef enum logic [3:0] {
		KEYON      = 4'd0,
		ALG_FB     = 4'd1,
		BLOCK_FNHI = 4'd2,
		FNLO       = 4'd3,
		RL         = 4'd4,
		DT_MUL     = 4'd5,
		TL         = 4'd6,
		KS_AR      = 4'd7,
		D1R        = 4'd8,
		D2R        = 4'd9,
		D1L_RR     = 4'd10
	} fm_reg_e;

	localparam int ADDR_W = 12;

	// address fields
	localparam int KIND_MSB = 11;
	localparam int KIND_LSB = 8;
	localparam int CH_MSB   = 6;
	localparam int CH_LSB   = 4;
	localparam int OP_MSB   = 1;
	localparam int OP_LSB   = 0;

	// kinds at or above this are unmapped
	localparam int NUM_KINDS = 11;

endpackage

// File: src/fm_regs_top.sv
`timescale 1ns/1ps

module fm_regs_top #(
	parameter logic [1:0] RL_RESET = 2'd3
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [11:0]            paddr,
	input  logic [7:0]             pwdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic                   slot_zero,
	output fm_slot_pkg::fm_stage_e stage,
	output logic                   carrier,
	output logic [10:0]            fnum,
	output logic [2:0]             block,
	output logic [2:0]             alg,
	output logic [2:0]             fb,
	output logic [1:0]             rl,
	output logic [2:0]             dt1,
	output logic [3:0]             mul,
	output logic [6:0]             tl,
	output logic [1:0]             ks,
	output logic [4:0]             ar,
	output logic [4:0]             d1r,
	output logic [4:0]             d2r,
	output logic [3:0]             rr,
	output logic [3:0]             d1l,
	output logic                   keyon,
	output logic                   keyoff
);

	fm_wr_if wr_bus ();

	fm_apb_host i_host (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pready  (pready),
		.pslverr (pslverr),
		.wr      (wr_bus.host)
	);

	fm_slot_regs #(.RL_RESET(RL_RESET)) i_regs (
		.clk       (clk),
		.rst       (rst),
		.wr        (wr_bus.regs),
		.slot_zero (slot_zero),
		.stage     (stage),
		.fnum      (fnum),
		.block     (block),
		.alg       (alg),
		.fb        (fb),
		.rl        (rl),
		.dt1       (dt1),
		.mul       (mul),
		.tl        (tl),
		.ks        (ks),
		.ar        (ar),
		.d1r       (d1r),
		.d2r       (d2r),
		.rr        (rr),
		.d1l       (d1l),
		.keyon     (keyon),
		.keyoff    (keyoff)
	);

	fm_alg_route i_route (
		.stage   (stage),
		.alg     (alg),
		.carrier (carrier)
	);

endmodule

// File: src/fm_shreg.sv
`timescale 1ns/1ps

module fm_shreg #(
	parameter int               WIDTH  = 8,
	parameter int               STAGES = 24,
	parameter logic [WIDTH-1:0] RSTVAL = '0
) (
	input  logic             clk,
	input  logic             rst,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] dout
);

	logic [WIDTH-1:0] mem [STAGES];

	// oldest word leaves at dout
	assign dout = mem[STAGES-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < STAGES; i++)
				mem[i] <= RSTVAL;
		end else begin
			mem[0] <= din;
			for (int i = 1; i < STAGES; i++)
				mem[i] <= mem[i-1];
		end
	end

endmodule

// File: src/fm_slot_pkg.sv
package fm_slot_pkg;

	localparam int NUM_SLOTS = 24;
	localparam int NUM_CH    = 6;
	localparam int NUM_OPS   = 4;
	localparam int SLOT_W    = 5;
	localparam int CH_W      = 3;
	localparam int OP_W      = 2;

	localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(NUM_SLOTS - 1);

	// slot group order in the pipeline: S1, S3, S2, S4
	typedef enum logic [1:0] {S1, S3, S2, S4} fm_stage_e;

	// dt1 3, mul 4, tl 7, ks 2, ar 5, d1r 5, d2r 5, d1l 4, rr 4
	localparam int OPREG_W = 39;
	// fnum 11, block 3, alg 3, fb 3
	localparam int CHREG_W = 20;

	// slot group, i.e. slot div 6
	function automatic logic [OP_W-1:0] slot_grp(input logic [SLOT_W-1:0] s);
		if (s >= SLOT_W'(3 * NUM_CH))
			return 2'd3;
		else if (s >= SLOT_W'(2 * NUM_CH))
			return 2'd2;
		else if (s >= SLOT_W'(NUM_CH))
			return 2'd1;
		else
			return 2'd0;
	endfunction

	// channel of a slot, i.e. slot mod 6
	function automatic logic [CH_W-1:0] slot_ch(input logic [SLOT_W-1:0] s);
		logic [SLOT_W-1:0] base;
		base = SLOT_W'(slot_grp(s)) * SLOT_W'(NUM_CH);
		return CH_W'(s - base);
	endfunction

endpackage

// File: src/fm_slot_regs.sv
`timescale 1ns/1ps

module fm_slot_regs #(
	parameter logic [1:0] RL_RESET = 2'd3
) (
	input  logic                     clk,
	input  logic                     rst,
	fm_wr_if.regs                    wr,
	output logic                     slot_zero,
	output fm_slot_pkg::fm_stage_e   stage,
	output logic [10:0]              fnum,
	output logic [2:0]               block,
	output logic [2:0]               alg,
	output logic [2:0]               fb,
	output logic [1:0]               rl,
	output logic [2:0]               dt1,
	output logic [3:0]               mul,
	output logic [6:0]               tl,
	output logic [1:0]               ks,
	output logic [4:0]               ar,
	output logic [4:0]               d1r,
	output logic [4:0]               d2r,
	output logic [3:0]               rr,
	output logic [3:0]               d1l,
	output logic                     keyon,
	output logic                     keyoff
);

	logic [fm_slot_pkg::SLOT_W-1:0] slot, slot_nxt;
	logic [fm_slot_pkg::SLOT_W-1:0] op_slot, tgt;
	logic is_op_kind;
	logic hit;

	logic up_kon, up_alg, up_blk, up_fnlo, up_rl;
	logic up_dt_mul, up_tl, up_ks_ar, up_d1r, up_d2r, up_d1l_rr;

	logic [fm_slot_pkg::OPREG_W-1:0] op_in, op_out;
	logic [fm_slot_pkg::CHREG_W-1:0] ch_in, ch_out;
	logic [1:0] rl_in;

	// free running slot counter, wraps after 23
	assign slot_nxt = (slot == fm_slot_pkg::LAST_SLOT) ? '0 : slot + 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			slot      <= fm_slot_pkg::LAST_SLOT;
			slot_zero <= 1'b0;
		end else begin
			slot      <= slot_nxt;
			slot_zero <= (slot_nxt == '0);
		end
	end

	assign stage = fm_slot_pkg::fm_stage_e'(fm_slot_pkg::slot_grp(slot));

	// target slot: ch + 6*op for operator kinds, ch otherwise
	assign is_op_kind = (wr.kind >= fm_map_pkg::DT_MUL);
	assign op_slot = {2'b00, wr.ch} + ({3'b000, wr.op} * 5'd6);
	assign tgt = is_op_kind ? op_slot : {2'b00, wr.ch};

	assign hit = wr.req && (slot == tgt);
	assign wr.done = hit;

	assign up_kon    = hit && (wr.kind == fm_map_pkg::KEYON);
	assign up_alg    = hit && (wr.kind == fm_map_pkg::ALG_FB);
	assign up_blk    = hit && (wr.kind == fm_map_pkg::BLOCK_FNHI);
	assign up_fnlo   = hit && (wr.kind == fm_map_pkg::FNLO);
	assign up_rl     = hit && (wr.kind == fm_map_pkg::RL);
	assign up_dt_mul = hit && (wr.kind == fm_map_pkg::DT_MUL);
	assign up_tl     = hit && (wr.kind == fm_map_pkg::TL);
	assign up_ks_ar  = hit && (wr.kind == fm_map_pkg::KS_AR);
	assign up_d1r    = hit && (wr.kind == fm_map_pkg::D1R);
	assign up_d2r    = hit && (wr.kind == fm_map_pkg::D2R);
	assign up_d1l_rr = hit && (wr.kind == fm_map_pkg::D1L_RR);

	// operator word, merged only at the target slot
	assign op_in = {
		up_dt_mul ? wr.data[6:4] : dt1,
		up_dt_mul ? wr.data[3:0] : mul,
		up_tl     ? wr.data[6:0] : tl,
		up_ks_ar  ? wr.data[7:6] : ks,
		up_ks_ar  ? wr.data[4:0] : ar,
		up_d1r    ? wr.data[4:0] : d1r,
		up_d2r    ? wr.data[4:0] : d2r,
		up_d1l_rr ? wr.data[7:4] : d1l,
		up_d1l_rr ? wr.data[3:0] : rr
	};

	assign {dt1, mul, tl, ks, ar, d1r, d2r, d1l, rr} = op_out;

	fm_shreg #(
		.WIDTH  (fm_slot_pkg::OPREG_W),
		.STAGES (fm_slot_pkg::NUM_SLOTS)
	) i_op_mem (
		.clk  (clk),
		.rst  (rst),
		.din  (op_in),
		.dout (op_out)
	);

	// channel word, fnum high bits travel with block
	assign ch_in = {
		up_blk  ? wr.data[2:0] : fnum[10:8],
		up_fnlo ? wr.data      : fnum[7:0],
		up_blk  ? wr.data[5:3] : block,
		up_alg  ? wr.data[2:0] : alg,
		up_alg  ? wr.data[5:3] : fb
	};

	assign {fnum, block, alg, fb} = ch_out;

	fm_shreg #(
		.WIDTH  (fm_slot_pkg::CHREG_W),
		.STAGES (fm_slot_pkg::NUM_CH)
	) i_ch_mem (
		.clk  (clk),
		.rst  (rst),
		.din  (ch_in),
		.dout (ch_out)
	);

	// panning has its own reset value
	assign rl_in = up_rl ? wr.data[7:6] : rl;

	fm_shreg #(
		.WIDTH  (2),
		.STAGES (fm_slot_pkg::NUM_CH),
		.RSTVAL (RL_RESET)
	) i_rl_mem (
		.clk  (clk),
		.rst  (rst),
		.din  (rl_in),
		.dout (rl)
	);

	fm_keyon i_keyon (
		.clk      (clk),
		.rst      (rst),
		.slot     (slot),
		.kon_req  (up_kon),
		.kon_ch   (wr.ch),
		.kon_mask (wr.data[7:4]),
		.keyon    (keyon),
		.keyoff   (keyoff)
	);

endmodule

// File: src/fm_wr_if.sv
`timescale 1ns/1ps

interface fm_wr_if;

	logic                               req;
	fm_map_pkg::fm_reg_e                kind;
	logic [fm_slot_pkg::CH_W-1:0]       ch;
	logic [fm_slot_pkg::OP_W-1:0]       op;
	logic [7:0]                         data;
	// one cycle, when the value enters the memory
	logic                               done;

	modport host (
		output req, kind, ch, op, data,
		input  done
	);

	modport regs (
		input  req, kind, ch, op, data,
		output done
	);

endinterface

// File: verification/fm_regs_checker.sv
`timescale 1ns/1ps

module fm_regs_checker (
	input logic        clk,
	input logic        rst,
	input logic        psel,
	input logic        penable,
	input logic [11:0] paddr,
	input logic        pready,
	input logic        pslverr,
	input logic        keyon,
	input logic        keyoff
);

	logic [5:0] wait_cnt;

	// cycles spent in the access phase without pready
	always_ff @(posedge clk) begin
		if (rst)
			wait_cnt <= '0;
		else if (psel && penable && !pready)
			wait_cnt <= wait_cnt + 1'b1;
		else
			wait_cnt <= '0;
	end

	a_err_needs_ready: assert property (@(posedge clk) disable iff (rst)
		pslverr |-> pready)
		else $error("pslverr seen without pready");

	a_ready_latency: assert property (@(posedge clk) disable iff (rst)
		(psel && penable) |-> (wait_cnt < 6'd27))
		else $error("pready later than 27 cycles into the access phase");

	// address held while the transfer is stalled
	a_addr_stable: assert property (@(posedge clk) disable iff (rst)
		(psel && penable && !pready) |=> $stable(paddr))
		else $error("paddr changed while the transfer was stalled");

	a_key_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(keyon && keyoff))
		else $error("keyon and keyoff high in the same cycle");

endmodule

// File: verification/fm_regs_tb.sv
`timescale 1ns/1ps

module fm_regs_tb;

	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic [4:0] ar;
		logic [4:0] d1r;
		logic [4:0] d2r;
		logic [3:0] d1l;
		logic [3:0] rr;
	} op_word_t;

	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  alg;
		logic [2:0]  fb;
		logic [1:0]  rl;
	} ch_word_t;

	localparam int WAIT_LIMIT = 40;

	logic clk, rst, psel, penable, pwrite;
	logic [11:0] paddr;
	logic [7:0] pwdata;
	logic pready, pslverr, slot_zero, carrier, keyon, keyoff;
	fm_slot_pkg::fm_stage_e stage;
	logic [10:0] fnum;
	logic [6:0] tl;
	logic [4:0] ar, d1r, d2r;
	logic [3:0] mul, rr, d1l;
	logic [2:0] block, alg, fb, dt1;
	logic [1:0] rl, ks;

	int seed = 6181;
	int err_count = 0;
	bit checking = 1'b0;
	int cur_slot;
	int kon_count, koff_count;

	// expected state per slot and per channel
	op_word_t m_op [24];
	ch_word_t m_ch [6];
	bit kreq [24];
	bit kapp [24];
	bit kpend [24];
	bit kpend_val [24];

	fm_regs_top #(.RL_RESET(2'd3)) i_fm_regs_top (.*);

	bind fm_regs_top fm_regs_checker i_checker (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.paddr   (paddr),
		.pready  (pready),
		.pslverr (pslverr),
		.keyon   (keyon),
		.keyoff  (keyoff)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_mismatch(input string msg);
		err_count++;
		$display("CHECK FAILED at time %0t: %s", $time, msg);
		abort_run();
	endtask

	function automatic logic [11:0] make_addr(input int kind, input int ch, input int op);
		logic [11:0] a;
		a = '0;
		a[fm_map_pkg::KIND_MSB:fm_map_pkg::KIND_LSB] = 4'(kind);
		a[fm_map_pkg::CH_MSB:fm_map_pkg::CH_LSB] = 3'(ch);
		a[fm_map_pkg::OP_MSB:fm_map_pkg::OP_LSB] = 2'(op);
		return a;
	endfunction

	// slot groups run S1, S3, S2, S4
	function automatic fm_slot_pkg::fm_stage_e stage_of_group(input int g);
		case (g)
			0: return fm_slot_pkg::S1;
			1: return fm_slot_pkg::S3;
			2: return fm_slot_pkg::S2;
			default: return fm_slot_pkg::S4;
		endcase
	endfunction

	// bit n set when slot group n is a carrier
	function automatic logic carrier_of(input logic [2:0] a, input int g);
		logic [3:0] groups;
		case (a)
			3'd4: groups = 4'b1100;
			3'd5, 3'd6: groups = 4'b1110;
			3'd7: groups = 4'b1111;
			default: groups = 4'b1000;
		endcase
		return groups[g];
	endfunction

	task automatic compare_slot(input int s);
		int c, g;
		op_word_t got_op;
		ch_word_t got_ch;
		logic exp_on, exp_off;
		c = s % 6;
		g = s / 6;
		got_op = {dt1, mul, tl, ks, ar, d1r, d2r, d1l, rr};
		got_ch = {fnum, block, alg, fb, rl};
		exp_on = kreq[s] && !kapp[s];
		exp_off = !kreq[s] && kapp[s];
		assert (slot_zero == (s == 0))
			else report_mismatch($sformatf("slot %0d slot_zero is %b", s, slot_zero));
		assert (stage == stage_of_group(g))
			else report_mismatch($sformatf("slot %0d stage is %0d", s, stage));
		assert (got_op == m_op[s])
			else report_mismatch($sformatf("slot %0d operator fields %h, expected %h",
				s, got_op, m_op[s]));
		assert (got_ch == m_ch[c])
			else report_mismatch($sformatf("slot %0d channel fields %h, expected %h",
				s, got_ch, m_ch[c]));
		assert (carrier == carrier_of(m_ch[c].alg, g))
			else report_mismatch($sformatf("slot %0d carrier is %b", s, carrier));
		assert (keyon == exp_on && keyoff == exp_off)
			else report_mismatch($sformatf("slot %0d keyon %b keyoff %b, expected %b %b",
				s, keyon, keyoff, exp_on, exp_off));
		if (keyon)
			kon_count++;
		if (keyoff)
			koff_count++;
	endtask

	// key state as the slot passes
	task automatic step_keys(input int s);
		kapp[s] = kreq[s];
		if (kpend[s]) begin
			kreq[s] = kpend_val[s];
			kpend[s] = 1'b0;
		end
	endtask

	task automatic apply_write(input logic [11:0] a, input logic [7:0] d);
		int c, sl;
		c = int'(a[fm_map_pkg::CH_MSB:fm_map_pkg::CH_LSB]);
		sl = c + 6 * int'(a[fm_map_pkg::OP_MSB:fm_map_pkg::OP_LSB]);
		case (fm_map_pkg::fm_reg_e'(a[fm_map_pkg::KIND_MSB:fm_map_pkg::KIND_LSB]))
			fm_map_pkg::KEYON: begin
				// group 0 loaded at the write, the others on their own slots
				kreq[c] = d[4];
				for (int n = 1; n < 4; n++) begin
					kpend[c + 6 * n] = 1'b1;
					kpend_val[c + 6 * n] = d[4 + n];
				end
			end
			fm_map_pkg::ALG_FB: begin
				m_ch[c].alg = d[2:0];
				m_ch[c].fb = d[5:3];
			end
			fm_map_pkg::BLOCK_FNHI: begin
				m_ch[c].fnum[10:8] = d[2:0];
				m_ch[c].block = d[5:3];
			end
			fm_map_pkg::FNLO: m_ch[c].fnum[7:0] = d;
			fm_map_pkg::RL: m_ch[c].rl = d[7:6];
			fm_map_pkg::DT_MUL: begin
				m_op[sl].dt1 = d[6:4];
				m_op[sl].mul = d[3:0];
			end
			fm_map_pkg::TL: m_op[sl].tl = d[6:0];
			fm_map_pkg::KS_AR: begin
				m_op[sl].ks = d[7:6];
				m_op[sl].ar = d[4:0];
			end
			fm_map_pkg::D1R: m_op[sl].d1r = d[4:0];
			fm_map_pkg::D2R: m_op[sl].d2r = d[4:0];
			fm_map_pkg::D1L_RR: begin
				m_op[sl].d1l = d[7:4];
				m_op[sl].rr = d[3:0];
			end
			default: ;
		endcase
	endtask

	always @(negedge clk) begin
		if (checking) begin
			compare_slot(cur_slot);
			step_keys(cur_slot);
			if (psel && penable && pready && pwrite && !pslverr)
				apply_write(paddr, pwdata);
			cur_slot = (cur_slot + 1) % 24;
		end
	end

	task automatic run_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic apb_transfer(input logic [11:0] addr, input logic [7:0] data,
		input logic wr_en, input logic expect_err);
		int cycles;
		logic got_err;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr_en;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!pready) begin
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("no pready within %0d cycles for address %h", WAIT_LIMIT, addr);
				abort_run();
			end
			@(negedge clk);
		end
		got_err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		assert (got_err == expect_err)
			else report_mismatch($sformatf("address %h pslverr %b", addr, got_err));
		if (expect_err) begin
			assert (cycles == 0)
				else report_mismatch($sformatf("error access %h took %0d cycles", addr, cycles));
		end
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [7:0] data);
		apb_transfer(addr, data, 1'b1, 1'b0);
	endtask

	task automatic check_key_counts(input int exp_on, input int exp_off);
		assert (kon_count == exp_on && koff_count == exp_off)
			else report_mismatch($sformatf("%0d keyon and %0d keyoff pulses, expected %0d %0d",
				kon_count, koff_count, exp_on, exp_off));
		kon_count = 0;
		koff_count = 0;
	endtask

	initial begin
		int kind, ch, op;
		logic [7:0] data;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		for (int i = 0; i < 24; i++) begin
			m_op[i] = '0;
			kreq[i] = 1'b0;
			kapp[i] = 1'b0;
			kpend[i] = 1'b0;
			kpend_val[i] = 1'b0;
		end
		for (int i = 0; i < 6; i++) begin
			m_ch[i] = '0;
			m_ch[i].rl = 2'd3;
		end
		kon_count = 0;
		koff_count = 0;
		cur_slot = 0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		checking = 1'b1;
		#1;
		// two rounds of reset values
		run_cycles(48);

		// random operator writes
		for (int i = 0; i < 24; i++) begin
			kind = int'(fm_map_pkg::DT_MUL) + int'($unsigned($random(seed)) % 6);
			ch = int'($unsigned($random(seed)) % 6);
			op = int'($unsigned($random(seed)) % 4);
			apb_write(make_addr(kind, ch, op), 8'($random(seed)));
		end
		run_cycles(30);

		// channel writes, op field ignored
		for (int c = 0; c < 6; c++) begin
			apb_write(make_addr(fm_map_pkg::BLOCK_FNHI, c, c % 4), 8'($random(seed)));
			apb_write(make_addr(fm_map_pkg::FNLO, c, 0), 8'($random(seed)));
			apb_write(make_addr(fm_map_pkg::RL, c, 1), 8'($random(seed)));
		end
		for (int a = 0; a < 8; a++) begin
			data = 8'($random(seed));
			data[2:0] = a[2:0];
			apb_write(make_addr(fm_map_pkg::ALG_FB, a % 6, 0), data);
			run_cycles(24);
		end

		// key on and off
		check_key_counts(0, 0);
		apb_write(make_addr(fm_map_pkg::KEYON, 2, 0), 8'hb0);
		run_cycles(48);
		check_key_counts(3, 0);
		apb_write(make_addr(fm_map_pkg::KEYON, 2, 0), 8'h00);
		run_cycles(48);
		check_key_counts(0, 3);
		apb_write(make_addr(fm_map_pkg::KEYON, 5, 0), 8'hf0);
		run_cycles(48);
		check_key_counts(4, 0);
		apb_write(make_addr(fm_map_pkg::KEYON, 5, 0), 8'h00);
		run_cycles(48);
		check_key_counts(0, 4);

		// unmapped kinds, bad channels and a read
		apb_transfer(make_addr(11, 0, 0), 8'hff, 1'b1, 1'b1);
		apb_transfer(make_addr(15, 3, 1), 8'hff, 1'b1, 1'b1);
		apb_transfer(make_addr(fm_map_pkg::TL, 6, 0), 8'h7f, 1'b1, 1'b1);
		apb_transfer(make_addr(fm_map_pkg::FNLO, 7, 0), 8'haa, 1'b1, 1'b1);
		apb_transfer(make_addr(fm_map_pkg::TL, 1, 2), 8'h55, 1'b0, 1'b1);
		run_cycles(30);

		// back to back, each one stalls in its access phase
		for (int i = 0; i < 8; i++) begin
			kind = 1 + int'($unsigned($random(seed)) % 10);
			ch = int'($unsigned($random(seed)) % 6);
			op = int'($unsigned($random(seed)) % 4);
			apb_write(make_addr(kind, ch, op), 8'($random(seed)));
		end
		run_cycles(30);

		if (err_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule
